//--- src/pixel_cfg.svh
// address map, block span, fifo sizing and sequence memory size
`ifndef PIXEL_CFG_SVH
`define PIXEL_CFG_SVH

// block base addresses, after the host offset is removed
`define GPIO_BASEADDR    16'h0000
`define FIFO_BASEADDR    16'h0020
`define SPI_RX_BASEADDR  16'h0100
`define TDC_BASEADDR     16'h0200
`define SEQ_GEN_BASEADDR 16'h1000

// registers per block, seq_gen memory sits just above its span
`define BLOCK_SPAN 16

`define SEQ_MEM_BYTES 256

// fifo sizes in 32-bit words
`define SRC_FIFO_DEPTH 8
`define OUT_FIFO_DEPTH 32
`define OUT_NEAR_FULL  24

// host address of register 0
`define BUS_OFFSET 16'h4000

`endif

//--- src/pixel_pkg.sv
// readout word type, data identifiers and fsm state types
package pixel_pkg;

    // identifier in bits 31:28, block-specific payload below
    typedef logic [31:0] word_t;

    typedef enum logic [3:0] {
        id_pixel_sr = 4'd1,
        id_tdc      = 4'd4
    } data_id_t;

    typedef enum logic {
        seq_idle,
        seq_run
    } seq_state_t;

    typedef enum logic {
        tdc_idle,
        tdc_high
    } tdc_state_t;

endpackage

//--- src/word_fifo.sv
// word_fifo: first-word-fall-through fifo of 32-bit words with fill level
`timescale 1ns/1ps
`include "pixel_cfg.svh"

module word_fifo #(
    parameter int DEPTH = `SRC_FIFO_DEPTH
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       wr,
    input  logic                       rd,
    input  pixel_pkg::word_t           wdata,
    output pixel_pkg::word_t           rdata,
    output logic                       empty,
    output logic                       full,
    output logic [$clog2(DEPTH+1)-1:0] level
);
    import pixel_pkg::*;

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    word_t         mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic          do_wr;
    logic          do_rd;

    // pointers wrap explicitly so any depth works
    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
        return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty = (level == '0);
    assign full  = (level == DEPTH);
    assign do_wr = wr && !full;
    assign do_rd = rd && !empty;
    // head word is visible before the pop
    assign rdata = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_wr, do_rd})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

endmodule

//--- src/gpio.sv
// gpio: supply-enable register with readback
`timescale 1ns/1ps
`include "pixel_cfg.svh"

module gpio #(
    parameter logic [15:0] BASEADDR = `GPIO_BASEADDR
) (
    input  logic        bus_clk,
    input  logic        arst_n,
    input  logic [15:0] bus_add,
    input  logic [7:0]  bus_wdata,
    input  logic        bus_rd,
    input  logic        bus_wr,
    output logic [7:0]  rdata,
    output logic        en_va1,
    output logic        en_va2,
    output logic        en_vd1,
    output logic        en_vd2
);
    logic [15:0] off;
    logic        reg_sel;
    logic [3:0]  en;

    // addresses below the base wrap to large offsets
    assign off     = bus_add - BASEADDR;
    assign reg_sel = (off < 16'(`BLOCK_SPAN)) && (off == 16'd0);

    // one pin per bit, va1 in bit 0
    assign {en_vd2, en_vd1, en_va2, en_va1} = en;

    always_ff @(posedge bus_clk or negedge arst_n) begin
        if (!arst_n) begin
            en    <= '0;
            rdata <= '0;
        end else begin
            if (bus_wr && reg_sel) begin
                en <= bus_wdata[3:0];
            end
            rdata <= (bus_rd && reg_sel) ? {4'b0000, en} : 8'h00;
        end
    end

endmodule

//--- src/seq_gen.sv
// seq_gen: bus-loaded pattern memory played back one byte per clock
`timescale 1ns/1ps
`include "pixel_cfg.svh"

module seq_gen #(
    parameter logic [15:0] BASEADDR = `SEQ_GEN_BASEADDR
) (
    input  logic        bus_clk,
    input  logic        arst_n,
    input  logic [15:0] bus_add,
    input  logic [7:0]  bus_wdata,
    input  logic        bus_rd,
    input  logic        bus_wr,
    output logic [7:0]  rdata,
    output logic [7:0]  seq_out
);
    import pixel_pkg::*;

    localparam logic [15:0] MEM_OFF = 16'(`BLOCK_SPAN);

    seq_state_t  state;
    logic [7:0]  mem [`SEQ_MEM_BYTES];
    logic [15:0] off;
    logic        sel;
    logic        mem_sel;
    logic [7:0]  mem_addr;
    logic        start;
    logic [7:0]  size;
    logic [8:0]  size_full;
    logic [8:0]  cnt;
    logic        done;

    assign off      = bus_add - BASEADDR;
    assign sel      = off < (MEM_OFF + 16'(`SEQ_MEM_BYTES));
    assign mem_sel  = sel && (off >= MEM_OFF);
    assign mem_addr = 8'(off - MEM_OFF);
    assign start    = bus_wr && sel && (off == 16'd0);
    // size 0 plays the full memory
    assign size_full = (size == 8'd0) ? 9'd256 : {1'b0, size};

    always_ff @(posedge bus_clk) begin
        if (bus_wr && mem_sel) begin
            mem[mem_addr] <= bus_wdata;
        end
    end

    // byte k leaves the register one edge after cnt reaches k
    always_ff @(posedge bus_clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= seq_idle;
            cnt     <= '0;
            size    <= '0;
            done    <= 1'b0;
            seq_out <= '0;
        end else begin
            if (bus_wr && sel && (off == 16'd1)) begin
                size <= bus_wdata;
            end
            if (start) begin
                state   <= seq_run;
                cnt     <= '0;
                done    <= 1'b0;
                seq_out <= '0;
            end else if (state == seq_run) begin
                if (cnt == size_full) begin
                    state   <= seq_idle;
                    done    <= 1'b1;
                    seq_out <= '0;
                end else begin
                    seq_out <= mem[cnt[7:0]];
                    cnt     <= cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge bus_clk or negedge arst_n) begin
        if (!arst_n) begin
            rdata <= '0;
        end else if (bus_rd && mem_sel) begin
            rdata <= mem[mem_addr];
        end else if (bus_rd && sel && (off == 16'd0)) begin
            rdata <= {7'b0, done};
        end else if (bus_rd && sel && (off == 16'd1)) begin
            rdata <= size;
        end else begin
            rdata <= '0;
        end
    end

endmodule

//--- src/spi_rx.sv
// spi_rx: pixel shift-register deserializer feeding tagged words to a fifo
`timescale 1ns/1ps
`include "pixel_cfg.svh"

module spi_rx #(
    parameter logic [15:0] BASEADDR = `SPI_RX_BASEADDR
) (
    input  logic             bus_clk,
    input  logic             arst_n,
    input  logic [15:0]      bus_add,
    input  logic [7:0]       bus_wdata,
    input  logic             bus_rd,
    input  logic             bus_wr,
    output logic [7:0]       rdata,
    input  logic             sen,
    input  logic             sdi,
    input  logic             fifo_read,
    output logic             fifo_empty,
    output pixel_pkg::word_t fifo_data
);
    import pixel_pkg::*;

    logic [15:0] off;
    logic        reg_sel;
    logic        en;
    logic [14:0] shift;
    logic [3:0]  bit_cnt;
    logic [11:0] index;
    logic        sample;
    logic        push;
    word_t       push_word;

    assign off     = bus_add - BASEADDR;
    assign reg_sel = (off < 16'(`BLOCK_SPAN)) && (off == 16'd0);
    assign sample  = en && sen;
    // 16th bit goes straight into the word, msb first
    assign push      = sample && (bit_cnt == 4'd15);
    assign push_word = {id_pixel_sr, index, shift, sdi};

    always_ff @(posedge bus_clk) begin
        if (sample) begin
            shift <= {shift[13:0], sdi};
        end
    end

    always_ff @(posedge bus_clk or negedge arst_n) begin
        if (!arst_n) begin
            en      <= 1'b0;
            rdata   <= '0;
            bit_cnt <= '0;
            index   <= '0;
        end else begin
            if (bus_wr && reg_sel) begin
                en <= bus_wdata[0];
            end
            rdata <= (bus_rd && reg_sel) ? {7'b0, en} : 8'h00;
            // partial words are dropped when the chip stops shifting
            if (!sen) begin
                bit_cnt <= '0;
            end else if (sample) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
            if (push) begin
                index <= index + 1'b1;
            end
        end
    end

    word_fifo #(.DEPTH(`SRC_FIFO_DEPTH)) fifo_i (
        .clk   (bus_clk),
        .arst_n(arst_n),
        .wr    (push),
        .rd    (fifo_read),
        .wdata (push_word),
        .rdata (fifo_data),
        .empty (fifo_empty),
        .full  (),
        .level ()
    );

endmodule

//--- src/tdc.sv
// tdc: hit-or pulse-width counter feeding tagged words to a fifo
`timescale 1ns/1ps
`include "pixel_cfg.svh"

module tdc #(
    parameter logic [15:0] BASEADDR = `TDC_BASEADDR
) (
    input  logic             bus_clk,
    input  logic             arst_n,
    input  logic [15:0]      bus_add,
    input  logic [7:0]       bus_wdata,
    input  logic             bus_rd,
    input  logic             bus_wr,
    output logic [7:0]       rdata,
    input  logic             tdc_in,
    input  logic             fifo_read,
    output logic             fifo_empty,
    output pixel_pkg::word_t fifo_data
);
    import pixel_pkg::*;

    tdc_state_t  state;
    logic [15:0] off;
    logic        sel;
    logic        en;
    logic [15:0] len;
    logic [11:0] evt;
    logic        push;
    word_t       push_word;

    assign off = bus_add - BASEADDR;
    assign sel = off < 16'(`BLOCK_SPAN);
    // word goes out on the first edge with the input low again
    assign push      = (state == tdc_high) && !tdc_in;
    assign push_word = {id_tdc, evt, len};

    always_ff @(posedge bus_clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= tdc_idle;
            en    <= 1'b0;
            len   <= '0;
            evt   <= '0;
        end else begin
            if (bus_wr && sel && (off == 16'd0)) begin
                en <= bus_wdata[0];
            end
            case (state)
                tdc_idle: begin
                    if (en && tdc_in) begin
                        state <= tdc_high;
                        len   <= 16'd1;
                    end
                end
                default: begin
                    if (!tdc_in) begin
                        state <= tdc_idle;
                        evt   <= evt + 1'b1;
                    end else if (en && (len != 16'hffff)) begin
                        // saturate on very long pulses
                        len <= len + 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge bus_clk or negedge arst_n) begin
        if (!arst_n) begin
            rdata <= '0;
        end else if (bus_rd && sel && (off == 16'd0)) begin
            rdata <= {7'b0, en};
        end else if (bus_rd && sel && (off == 16'd1)) begin
            rdata <= evt[7:0];
        end else begin
            rdata <= '0;
        end
    end

    word_fifo #(.DEPTH(`SRC_FIFO_DEPTH)) fifo_i (
        .clk   (bus_clk),
        .arst_n(arst_n),
        .wr    (push),
        .rd    (fifo_read),
        .wdata (push_word),
        .rdata (fifo_data),
        .empty (fifo_empty),
        .full  (),
        .level ()
    );

endmodule

//--- src/rrp_arbiter.sv
// rrp_arbiter: round-robin merge of two word sources
`timescale 1ns/1ps

module rrp_arbiter (
    input  logic             bus_clk,
    input  logic             arst_n,
    input  logic [1:0]       write_req,
    input  pixel_pkg::word_t data_in0,
    input  pixel_pkg::word_t data_in1,
    input  logic             hold,
    output logic [1:0]       read_grant,
    output logic             write_out,
    output pixel_pkg::word_t data_out
);
    // source served most recently
    logic last;

    always_comb begin
        read_grant = 2'b00;
        if (!hold) begin
            if (write_req[0] && (!write_req[1] || last)) begin
                read_grant[0] = 1'b1;
            end else if (write_req[1]) begin
                read_grant[1] = 1'b1;
            end
        end
    end

    // pop and write happen in the same cycle
    assign write_out = |read_grant;
    assign data_out  = read_grant[1] ? data_in1 : data_in0;

    always_ff @(posedge bus_clk or negedge arst_n) begin
        if (!arst_n) begin
            last <= 1'b0;
        end else if (write_out) begin
            last <= read_grant[1];
        end
    end

endmodule

//--- src/out_fifo.sv
// out_fifo: output word buffer drained a byte at a time, with fill-level register
`timescale 1ns/1ps
`include "pixel_cfg.svh"

module out_fifo #(
    parameter logic [15:0] BASEADDR = `FIFO_BASEADDR
) (
    input  logic             bus_clk,
    input  logic             arst_n,
    input  logic [15:0]      bus_add,
    input  logic [7:0]       bus_wdata,
    input  logic             bus_rd,
    input  logic             bus_wr,
    output logic [7:0]       rdata,
    input  logic             usb_read,
    output logic [7:0]       fd,
    input  logic             fifo_write,
    input  pixel_pkg::word_t fifo_data,
    output logic             near_full
);
    import pixel_pkg::*;

    localparam int LW = $clog2(`OUT_FIFO_DEPTH + 1);

    logic [15:0]   off;
    logic          reg_sel;
    word_t         head;
    logic          empty;
    logic [LW-1:0] level;
    logic [1:0]    byte_sel;
    logic          pop;

    assign off     = bus_add - BASEADDR;
    assign reg_sel = (off < 16'(`BLOCK_SPAN)) && (off == 16'd0);
    // low byte first, pop after the top byte
    assign pop       = usb_read && !empty && (byte_sel == 2'd3);
    assign fd        = empty ? 8'h00 : head[8*byte_sel +: 8];
    assign near_full = level >= LW'(`OUT_NEAR_FULL);

    always_ff @(posedge bus_clk or negedge arst_n) begin
        if (!arst_n) begin
            byte_sel <= '0;
            rdata    <= '0;
        end else begin
            if (usb_read && !empty) begin
                byte_sel <= byte_sel + 1'b1;
            end
            // fill level is read-only, writes have no effect
            rdata <= (bus_rd && reg_sel && !bus_wr) ? 8'(level) : 8'h00;
        end
    end

    word_fifo #(.DEPTH(`OUT_FIFO_DEPTH)) fifo_i (
        .clk   (bus_clk),
        .arst_n(arst_n),
        .wr    (fifo_write),
        .rd    (pop),
        .wdata (fifo_data),
        .rdata (head),
        .empty (empty),
        .full  (),
        .level (level)
    );

endmodule

//--- src/pixel.sv
// pixel: readout controller top with address decode and read-data merge
`timescale 1ns/1ps
`include "pixel_cfg.svh"

module pixel (
    input  logic        bus_clk,
    input  logic        arst_n,
    input  logic [15:0] add,
    input  logic        rd_b,
    input  logic        wr_b,
    input  logic [7:0]  bus_wdata,
    output logic [7:0]  bus_rdata,
    input  logic        fread,
    input  logic        fstrobe,
    output logic [7:0]  fd,
    output logic        sr_in,
    output logic        global_sr_en,
    output logic        global_ctr_ld,
    output logic        global_dac_ld,
    output logic        pixel_sr_en,
    output logic        inject,
    output logic        lemo_tx,
    input  logic        pixel_sr_out,
    input  logic        hit_or,
    output logic        en_va1,
    output logic        en_va2,
    output logic        en_vd1,
    output logic        en_vd2,
    output logic        led1
);
    import pixel_pkg::*;

    logic [15:0] bus_add;
    logic        bus_rd;
    logic        bus_wr;
    logic        usb_read;
    logic [7:0]  gpio_rdata;
    logic [7:0]  seq_rdata;
    logic [7:0]  spi_rdata;
    logic [7:0]  tdc_rdata;
    logic [7:0]  fifo_rdata;
    logic [7:0]  seq_out;
    logic        spi_fifo_read;
    logic        spi_fifo_empty;
    word_t       spi_fifo_data;
    logic        tdc_fifo_read;
    logic        tdc_fifo_empty;
    word_t       tdc_fifo_data;
    logic        arb_write;
    word_t       arb_data;
    logic        fifo_near_full;

    assign bus_add  = add - `BUS_OFFSET;
    assign bus_rd   = ~rd_b;
    assign bus_wr   = ~wr_b;
    assign usb_read = fread && fstrobe;
    // unselected blocks return zero
    assign bus_rdata = gpio_rdata | seq_rdata | spi_rdata | tdc_rdata | fifo_rdata;

    assign sr_in         = seq_out[0];
    assign global_sr_en  = seq_out[1];
    assign global_ctr_ld = seq_out[2];
    assign global_dac_ld = seq_out[3];
    assign pixel_sr_en   = seq_out[4];
    assign inject        = seq_out[5];
    assign lemo_tx       = seq_out[5];
    assign led1          = fifo_near_full;

    gpio #(.BASEADDR(`GPIO_BASEADDR)) gpio_i (
        .bus_clk, .arst_n, .bus_add, .bus_wdata, .bus_rd, .bus_wr,
        .rdata(gpio_rdata),
        .en_va1, .en_va2, .en_vd1, .en_vd2
    );

    seq_gen #(.BASEADDR(`SEQ_GEN_BASEADDR)) seq_gen_i (
        .bus_clk, .arst_n, .bus_add, .bus_wdata, .bus_rd, .bus_wr,
        .rdata  (seq_rdata),
        .seq_out(seq_out)
    );

    // the chip shifts on bus_clk while pixel_sr_en is high
    spi_rx #(.BASEADDR(`SPI_RX_BASEADDR)) spi_rx_i (
        .bus_clk, .arst_n, .bus_add, .bus_wdata, .bus_rd, .bus_wr,
        .rdata     (spi_rdata),
        .sen       (seq_out[4]),
        .sdi       (pixel_sr_out),
        .fifo_read (spi_fifo_read),
        .fifo_empty(spi_fifo_empty),
        .fifo_data (spi_fifo_data)
    );

    tdc #(.BASEADDR(`TDC_BASEADDR)) tdc_i (
        .bus_clk, .arst_n, .bus_add, .bus_wdata, .bus_rd, .bus_wr,
        .rdata     (tdc_rdata),
        .tdc_in    (hit_or),
        .fifo_read (tdc_fifo_read),
        .fifo_empty(tdc_fifo_empty),
        .fifo_data (tdc_fifo_data)
    );

    // source 0 is the deserializer, source 1 the tdc
    rrp_arbiter rrp_arbiter_i (
        .bus_clk,
        .arst_n,
        .write_req ({~tdc_fifo_empty, ~spi_fifo_empty}),
        .data_in0  (spi_fifo_data),
        .data_in1  (tdc_fifo_data),
        .hold      (fifo_near_full),
        .read_grant({tdc_fifo_read, spi_fifo_read}),
        .write_out (arb_write),
        .data_out  (arb_data)
    );

    out_fifo #(.BASEADDR(`FIFO_BASEADDR)) out_fifo_i (
        .bus_clk, .arst_n, .bus_add, .bus_wdata, .bus_rd, .bus_wr,
        .rdata     (fifo_rdata),
        .usb_read  (usb_read),
        .fd        (fd),
        .fifo_write(arb_write),
        .fifo_data (arb_data),
        .near_full (fifo_near_full)
    );

endmodule

//--- test/pixel_tests.svh
// directed test tasks for reset and gpio, playback, pixel readback, tdc widths and merge
task automatic reset_and_gpio();
    logic [7:0] d;
    logic [3:0] nib;
    begin_test("reset_gpio");
    check_byte("seq pins", 8'h00, seq_pins());
    check_bit("lemo_tx", 1'b0, lemo_tx);
    check_byte("supply enables", 8'h00, {4'h0, en_vd2, en_vd1, en_va2, en_va1});
    check_byte("fd", 8'h00, fd);
    check_bit("led1", 1'b0, led1);
    for (int i = 0; i < 4; i++) begin
        nib = 4'(random_bits(4));
        bus_write(gpio_addr, {4'h0, nib});
        check_byte("supply enables", {4'h0, nib}, {4'h0, en_vd2, en_vd1, en_va2, en_va1});
        bus_read(gpio_addr, d);
        check_byte("gpio readback", {4'h0, nib}, d);
    end
    end_test();
endtask

task automatic sequence_playback();
    logic [7:0] pat [20];
    logic [7:0] d;
    begin_test("seq_playback");
    for (int k = 0; k < 20; k++) begin
        pat[k] = 8'(random_bits(8));
        bus_write(seq_addr + 16'd16 + 16'(k), pat[k]);
    end
    bus_write(seq_addr + 16'd1, 8'd20);
    bus_write(seq_addr, 8'h00);
    // byte k appears after edge N+1+k
    for (int k = 0; k < 20; k++) begin
        @(negedge bus_clk);
        check_byte("seq pins", {2'b00, pat[k][5:0]}, seq_pins());
        check_bit("lemo_tx", pat[k][5], lemo_tx);
    end
    @(negedge bus_clk);
    check_byte("seq pins after end", 8'h00, seq_pins());
    bus_read(seq_addr, d);
    check_byte("done", 8'h01, d);
    end_test();
endtask

task automatic pixel_sr_readback();
    word_t w;
    begin_test("pixel_sr");
    // only pixel_sr_en set in every byte
    for (int k = 0; k < sr_cycles; k++) begin
        bus_write(seq_addr + 16'd16 + 16'(k), 8'h10);
    end
    bus_write(seq_addr + 16'd1, 8'(sr_cycles));
    bus_write(spi_addr, 8'h01);
    shift_pixel_sr();
    wait_level(3);
    repeat (3) begin
        drain_word(w);
        check_word("pixel_sr word", exp_spi.pop_front(), w);
    end
    end_test();
endtask

task automatic tdc_pulse_widths();
    word_t      w;
    logic [7:0] d;
    begin_test("tdc_pulses");
    bus_write(tdc_addr, 8'h01);
    make_pulse_lengths(6);
    apply_pulses();
    wait_level(6);
    repeat (6) begin
        drain_word(w);
        check_word("tdc word", exp_tdc.pop_front(), w);
    end
    bus_read(tdc_addr + 16'd1, d);
    check_byte("event counter", 8'(tdc_event), d);
    end_test();
endtask

task automatic merge_and_backpressure();
    word_t      w;
    logic [7:0] d;
    int         total;
    begin_test("merge_backpressure");
    // 12 pixel words and 14 tdc words overrun the near-full level by two
    make_pulse_lengths(14);
    fork
        repeat (4) shift_pixel_sr();
        apply_pulses();
    join
    check_bit("led1", 1'b1, led1);
    bus_read(fifo_addr, d);
    check_byte("fill level", 8'(`OUT_NEAR_FULL), d);
    total = exp_spi.size() + exp_tdc.size();
    for (int i = 0; i < total; i++) begin
        wait_level(1);
        drain_word(w);
        match_word(w);
    end
    if (exp_spi.size() != 0 || exp_tdc.size() != 0) begin
        $display("[FAIL] %s: some expected words never came out", cur_test);
        errors++;
    end
    // nothing may be left once every expected word is out
    bus_read(fifo_addr, d);
    check_byte("fill level after drain", 8'h00, d);
    end_test();
endtask

//--- test/pixel_tb.sv
// pixel_tb: clock, reset, lfsr, bus and drain tasks, compare tasks, timeout and summary
`timescale 1ns/1ps
`include "pixel_cfg.svh"

module pixel_tb;
    import pixel_pkg::*;

    // summed test length is under 2000 cycles
    localparam int cycle_limit = 4000;
    localparam int sr_cycles   = 48;

    localparam logic [15:0] gpio_addr = `BUS_OFFSET + `GPIO_BASEADDR;
    localparam logic [15:0] fifo_addr = `BUS_OFFSET + `FIFO_BASEADDR;
    localparam logic [15:0] spi_addr  = `BUS_OFFSET + `SPI_RX_BASEADDR;
    localparam logic [15:0] tdc_addr  = `BUS_OFFSET + `TDC_BASEADDR;
    localparam logic [15:0] seq_addr  = `BUS_OFFSET + `SEQ_GEN_BASEADDR;

    logic        bus_clk;
    logic        arst_n;
    logic [15:0] add;
    logic        rd_b;
    logic        wr_b;
    logic [7:0]  bus_wdata;
    logic [7:0]  bus_rdata;
    logic        fread;
    logic        fstrobe;
    logic [7:0]  fd;
    logic        sr_in;
    logic        global_sr_en;
    logic        global_ctr_ld;
    logic        global_dac_ld;
    logic        pixel_sr_en;
    logic        inject;
    logic        lemo_tx;
    logic        pixel_sr_out;
    logic        hit_or;
    logic        en_va1;
    logic        en_va2;
    logic        en_vd1;
    logic        en_vd2;
    logic        led1;

    logic [31:0] lfsr = 32'h1ef8;
    string       cur_test = "none";
    int          errors;
    int          err_mark;
    int          n_pass;
    int          n_fail;
    int          cycles;
    int          spi_index;
    int          tdc_event;
    word_t       exp_spi [$];
    word_t       exp_tdc [$];
    int          pulse_lens [$];

    pixel pixel_i (.*);

    initial begin
        bus_clk = 1'b0;
        forever #20 bus_clk = ~bus_clk;
    end

    // galois form, taps x^32 + x^22 + x^2 + x + 1
    function automatic logic next_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) begin
            lfsr = lfsr ^ 32'h80200003;
        end
        return b;
    endfunction

    function automatic int random_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(next_bit());
        end
        return v;
    endfunction

    function automatic logic [7:0] seq_pins();
        return {2'b00, inject, pixel_sr_en, global_dac_ld, global_ctr_ld, global_sr_en, sr_in};
    endfunction

    task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            $display("[FAIL] %s %s: expected %h, actual %h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_word(input string what, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("[FAIL] %s %s: expected %h, actual %h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %s %s: expected %b, actual %b", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        err_mark = errors;
    endtask

    task automatic end_test();
        if (errors == err_mark) begin
            $display("test %s: ok", cur_test);
            n_pass++;
        end else begin
            $display("test %s: %0d errors", cur_test, errors - err_mark);
            n_fail++;
        end
    endtask

    // all bus and drain tasks start and end just after a falling edge
    task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
        add = a;
        bus_wdata = d;
        wr_b = 1'b0;
        @(negedge bus_clk);
        wr_b = 1'b1;
    endtask

    // data is valid in the cycle after the capturing edge
    task automatic bus_read(input logic [15:0] a, output logic [7:0] d);
        add = a;
        rd_b = 1'b0;
        @(negedge bus_clk);
        d = bus_rdata;
        rd_b = 1'b1;
    endtask

    task automatic drain_word(output word_t w);
        w = '0;
        for (int b = 0; b < 4; b++) begin
            w[8*b +: 8] = fd;
            fread = 1'b1;
            fstrobe = 1'b1;
            @(negedge bus_clk);
        end
        fread = 1'b0;
        fstrobe = 1'b0;
    endtask

    task automatic wait_level(input int min_words);
        logic [7:0] lvl;
        lvl = 8'h00;
        while (int'(lvl) < min_words) begin
            bus_read(fifo_addr, lvl);
        end
    endtask

    // one playback of the pattern, bits go out msb first
    task automatic shift_pixel_sr();
        logic [15:0] data;
        logic        b;
        data = '0;
        bus_write(seq_addr, 8'h00);
        for (int i = 0; i < sr_cycles; i++) begin
            @(negedge bus_clk);
            check_bit("pixel_sr_en", 1'b1, pixel_sr_en);
            b = next_bit();
            pixel_sr_out = b;
            data = {data[14:0], b};
            if (i % 16 == 15) begin
                exp_spi.push_back({id_pixel_sr, 12'(spi_index), data});
                spi_index++;
            end
        end
        @(negedge bus_clk);
        pixel_sr_out = 1'b0;
    endtask

    task automatic make_pulse_lengths(input int n);
        for (int i = 0; i < n; i++) begin
            pulse_lens.push_back(1 + random_bits(6) % 40);
        end
    endtask

    task automatic apply_pulses();
        int len;
        while (pulse_lens.size() > 0) begin
            len = pulse_lens.pop_front();
            exp_tdc.push_back({id_tdc, 12'(tdc_event), 16'(len)});
            tdc_event++;
            hit_or = 1'b1;
            repeat (len) @(negedge bus_clk);
            hit_or = 1'b0;
            // gap lets the fsm fall back to idle
            repeat (3) @(negedge bus_clk);
        end
    endtask

    task automatic match_word(input word_t w);
        if (w[31:28] == id_pixel_sr && exp_spi.size() > 0) begin
            check_word("pixel_sr word", exp_spi.pop_front(), w);
        end else if (w[31:28] == id_tdc && exp_tdc.size() > 0) begin
            check_word("tdc word", exp_tdc.pop_front(), w);
        end else begin
            $display("[FAIL] %s: unexpected word %h came out of the buffer", cur_test, w);
            errors++;
        end
    endtask

    task automatic print_counts();
        $display("tests run: %0d, ok: %0d, failing: %0d", n_pass + n_fail, n_pass, n_fail);
    endtask

    `include "pixel_tests.svh"

    initial begin
        arst_n = 1'b0;
        add = `BUS_OFFSET;
        rd_b = 1'b1;
        wr_b = 1'b1;
        bus_wdata = 8'h00;
        fread = 1'b0;
        fstrobe = 1'b0;
        pixel_sr_out = 1'b0;
        hit_or = 1'b0;
        repeat (4) @(negedge bus_clk);
        arst_n = 1'b1;
        reset_and_gpio();
        sequence_playback();
        pixel_sr_readback();
        tdc_pulse_widths();
        merge_and_backpressure();
        print_counts();
        if (n_fail == 0 && errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge bus_clk);
            cycles++;
        end
        $display("timeout: the run hung after %0d cycles in test %s", cycles, cur_test);
        print_counts();
        $display("Some tests failed");
        $finish;
    end

endmodule

//--- pixel.f
+incdir+src
+incdir+test
src/pixel_pkg.sv
src/word_fifo.sv
src/gpio.sv
src/seq_gen.sv
src/spi_rx.sv
src/tdc.sv
src/rrp_arbiter.sv
src/out_fifo.sv
src/pixel.sv
test/pixel_tb.sv
